// ==== design/video_bypass_defines.svh ====
// ----------------------------------------------------------------------
// Display timing constants for the bypass picture unit
// Line, frame and pixel limits plus the CPU register addresses
// ----------------------------------------------------------------------
`ifndef VIDEO_BYPASS_DEFINES_SVH
`define VIDEO_BYPASS_DEFINES_SVH

// Horizontal and vertical limits
`define VB_HCNT_LAST    7'd113
`define VB_LAST_LINE    8'd153
`define VB_VBLANK_LINE  8'd144

// Pixel counter limits, 8 hidden pixels then 160 shown
`define VB_PCNT_END     8'd168
`define VB_PCNT_VISIBLE 8'd8

// Background fetch takes 6 cycles, done from cycle 5
`define VB_FETCH_DONE   3'd5

// CPU register addresses
`define VB_ADDR_LCDC    8'h40
`define VB_ADDR_SCX     8'h43
`define VB_ADDR_BGPI    8'h68
`define VB_ADDR_BGPD    8'h69

`define VB_WHITE        15'h7FFF

`endif

// ==== design/video_bypass_pkg.sv ====
// ----------------------------------------------------------------------
// Shared types for the bypass picture unit
// ----------------------------------------------------------------------
package video_bypass_pkg;

    // One CPU register write as seen by the register file
    typedef struct packed {
        logic       sel;
        logic       wr;
        logic [7:0] addr;
        logic [7:0] data;
    } cpu_wr_t;

    // Register state read by the timing logic
    typedef struct packed {
        logic       lcd_enable;
        logic [2:0] scx_fine;
    } lcd_regs_t;

    // Control to datapath timing
    typedef struct packed {
        logic slot;
        logic mid_slot;
        logic end_of_line;
        logic vblank;
        logic pcnt_reset;
        logic restart;
        logic draw;
    } line_timing_t;

    // Picture unit mode, as read back by the CPU
    typedef enum logic [1:0] {
        MODE_HBLANK = 2'd0,
        MODE_VBLANK = 2'd1,
        MODE_OAM    = 2'd2,
        MODE_DRAW   = 2'd3
    } mode_t;

endpackage

// ==== design/lcd_restart_seq.sv ====
// ----------------------------------------------------------------------
// Display re-enable sequencer
// Holds the timing in reset until the real unit reaches a known point
// ----------------------------------------------------------------------
module lcd_restart_seq (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ce,
    input  video_bypass_pkg::lcd_regs_t   regs,
    input  logic                          lcd_vsync,
    input  logic [1:0]                    mode_real,
    output logic                          restart,
    output logic                          overwrite,
    output logic                          vsync_overwrite,
    output logic                          lcd_on
);
    import video_bypass_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_WAIT_VSYNC  = 3'd1,
        ST_WAIT_VBLANK = 3'd2,
        ST_WAIT_OAM    = 3'd3,
        ST_WAIT_CE     = 3'd4,
        ST_WAIT_HBLANK = 3'd5
    } state_t;

    state_t state;
    logic   enable_d;

    always_ff @(posedge clk) begin
        if (reset) begin
            enable_d <= 1'b0;
            restart  <= 1'b0;
            state    <= ST_IDLE;
        end else begin
            // Delayed enable, sampled on the pixel enable only
            if (ce) begin
                enable_d <= regs.lcd_enable;
            end
            case (state)
                ST_IDLE: if (!enable_d && regs.lcd_enable) begin
                    state <= ST_WAIT_VSYNC;
                end
                // Own frame start reached, hold timing in reset
                ST_WAIT_VSYNC: if (lcd_vsync) begin
                    state   <= ST_WAIT_VBLANK;
                    restart <= 1'b1;
                end
                ST_WAIT_VBLANK: if (mode_real == MODE_VBLANK) begin
                    state <= ST_WAIT_OAM;
                end
                // Real unit starts its first line
                ST_WAIT_OAM: if (ce && mode_real == MODE_OAM) begin
                    state <= ST_WAIT_CE;
                end
                ST_WAIT_CE: if (ce) begin
                    state   <= ST_WAIT_HBLANK;
                    restart <= 1'b0;
                end
                ST_WAIT_HBLANK: if (mode_real == MODE_HBLANK) begin
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Output overrides while the two units are out of step
    assign overwrite       = (state == ST_WAIT_VSYNC) || (state == ST_WAIT_VBLANK) ||
                             (state == ST_WAIT_OAM);
    assign vsync_overwrite = (state == ST_WAIT_VBLANK) || (state == ST_WAIT_OAM);
    assign lcd_on          = !vsync_overwrite;

endmodule

// ==== design/video_timing_ctrl.sv ====
// ----------------------------------------------------------------------
// Line and frame timing control
// Slot and line counters, end of line, vsync and the mode register
// ----------------------------------------------------------------------
`include "video_bypass_defines.svh"

module video_timing_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            ce,
    input  logic                            is_gbc,
    input  logic                            lcd_on,
    input  logic                            restart,
    input  logic                            pcnt_at_end,
    output video_bypass_pkg::line_timing_t  timing,
    output logic                            lcd_vsync,
    output video_bypass_pkg::mode_t         mode
);
    import video_bypass_pkg::*;

    logic [1:0] h_div_cnt;
    logic [6:0] h_cnt;
    logic [7:0] v_cnt;
    logic       end_of_line;
    logic       vblank_t;
    logic       vblank_l;
    logic       vcnt_eol_l;
    logic       vcnt_reset;
    logic       draw_end_l;
    logic       slot;
    logic       mid_slot;
    logic       hcnt_end;
    logic       vblank;
    logic       pcnt_reset;
    logic       draw;
    logic       wrap_slot;
    logic       mode_vblank;

    // Slot strobe and the strobe halfway through a slot
    assign slot       = lcd_on && (h_div_cnt == 2'd0);
    assign mid_slot   = lcd_on && (h_div_cnt == 2'd2);
    assign hcnt_end   = (h_cnt == `VB_HCNT_LAST);
    assign vblank     = (v_cnt >= `VB_VBLANK_LINE);
    assign pcnt_reset = slot && end_of_line && !vblank;
    assign draw       = lcd_on && !draw_end_l;
    // Colour model samples the wrap half a slot later
    assign wrap_slot  = is_gbc ? mid_slot : slot;
    // DMG drops vblank one cycle early in the mode readback
    assign mode_vblank = is_gbc ? vblank_l : (vblank_l && vblank_t);

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            h_div_cnt   <= 2'd0;
            h_cnt       <= 7'd0;
            v_cnt       <= 8'd0;
            end_of_line <= 1'b0;
            vblank_t    <= 1'b0;
            vblank_l    <= 1'b0;
            vcnt_eol_l  <= 1'b0;
            vcnt_reset  <= 1'b0;
            lcd_vsync   <= 1'b0;
            draw_end_l  <= 1'b0;
            mode        <= MODE_HBLANK;
        end else if (ce) begin
            h_div_cnt <= h_div_cnt + 2'd1;
            if (slot) begin
                h_cnt <= hcnt_end ? 7'd0 : h_cnt + 7'd1;
            end

            // End of line spans one slot, vblank latched inside it
            if (mid_slot && hcnt_end) begin
                end_of_line <= 1'b1;
            end else if (end_of_line) begin
                if (slot) begin
                    vblank_t <= vblank;
                end
                if (mid_slot) begin
                    end_of_line <= 1'b0;
                end
            end
            vblank_l <= vblank_t;

            if (!vcnt_reset && mid_slot && hcnt_end) begin
                v_cnt <= v_cnt + 8'd1;
            end

            // Line 153 goes back to 0 and then holds for one more line
            if (wrap_slot) begin
                vcnt_eol_l <= end_of_line;
                if (vcnt_eol_l && !end_of_line) begin
                    vcnt_reset <= (v_cnt == `VB_LAST_LINE);
                    if (v_cnt == `VB_LAST_LINE) begin
                        v_cnt <= 8'd0;
                    end
                    lcd_vsync <= (v_cnt == 8'd0);
                end
            end

            // Drawing stops at the last pixel, rearmed at line start
            draw_end_l <= pcnt_reset ? 1'b0 : (draw_end_l || pcnt_at_end);

            if (mode_vblank) begin
                mode <= MODE_VBLANK;
            end else if (draw) begin
                mode <= MODE_DRAW;
            end else begin
                mode <= MODE_HBLANK;
            end
        end
    end

    assign timing = '{slot:        slot,
                      mid_slot:    mid_slot,
                      end_of_line: end_of_line,
                      vblank:      vblank_l,
                      pcnt_reset:  pcnt_reset,
                      restart:     restart,
                      draw:        draw};

endmodule

// ==== design/lcd_reg_file.sv ====
// ----------------------------------------------------------------------
// CPU register file
// LCD control, fine scroll and the colour background palette
// ----------------------------------------------------------------------
`include "video_bypass_defines.svh"

module lcd_reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ce_cpu,
    input  logic                          is_gbc,
    input  logic                          is_gbc_mode,
    input  video_bypass_pkg::cpu_wr_t     cpu,
    input  video_bypass_pkg::mode_t       mode,
    output video_bypass_pkg::lcd_regs_t   regs,
    output logic [14:0]                   bg_color0
);
    import video_bypass_pkg::*;

    // Palette index with auto increment flag
    logic [5:0] bgpi;
    logic       bgpi_ai;
    logic       wr_en;

    // 64 byte background palette, 8 palettes of 4 colours
    logic [7:0] bgpd [64];

    assign wr_en = ce_cpu && cpu.sel && cpu.wr;

    //----------------------------------------------------------------------
    // Control and scroll registers
    always_ff @(posedge clk) begin
        if (reset) begin
            // Display starts switched off
            regs    <= '0;
            bgpi    <= 6'd0;
            bgpi_ai <= 1'b0;
        end else if (wr_en) begin
            case (cpu.addr)
                `VB_ADDR_LCDC: regs.lcd_enable <= cpu.data[7];
                `VB_ADDR_SCX:  regs.scx_fine   <= cpu.data[2:0];
                `VB_ADDR_BGPI: if (is_gbc) begin
                    bgpi    <= cpu.data[5:0];
                    bgpi_ai <= cpu.data[7];
                end
                // Index still steps when the data write is blocked
                `VB_ADDR_BGPD: if (is_gbc && is_gbc_mode && bgpi_ai) begin
                    bgpi <= bgpi + 6'd1;
                end
                default: ;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // Palette memory, locked while the line is being drawn
    always_ff @(posedge clk) begin
        if (wr_en && is_gbc && is_gbc_mode && cpu.addr == `VB_ADDR_BGPD &&
            mode != MODE_DRAW) begin
            bgpd[bgpi] <= cpu.data;
        end
    end

    // Colour 0 of palette 0, little endian RGB555
    assign bg_color0 = {bgpd[1][6:0], bgpd[0]};

endmodule

// ==== design/pixel_pacer.sv ====
// ----------------------------------------------------------------------
// Pixel pacing
// Fine scroll skip and background fetch pacing drive the pixel strobe
// ----------------------------------------------------------------------
`include "video_bypass_defines.svh"

module pixel_pacer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            ce,
    input  video_bypass_pkg::line_timing_t  timing,
    input  video_bypass_pkg::lcd_regs_t     regs,
    output logic                            pcnt_at_end,
    output logic                            pixel_strobe
);
    logic [7:0] pcnt;
    logic [2:0] skip_cnt;
    logic       skip_done;
    logic [2:0] fetch_cycle;
    logic [3:0] shift_cnt;
    logic       skip_end;
    logic       skip_en;
    logic       shift_empty;
    logic       fetch_done;

    assign shift_empty = (shift_cnt == 4'd0);
    assign fetch_done  = (fetch_cycle >= `VB_FETCH_DONE);
    // Skip stops at the fine scroll, or when the counter saturates
    assign skip_end    = (skip_cnt == regs.scx_fine) || (&skip_cnt);
    assign skip_en     = !skip_done && !skip_end;
    assign pcnt_at_end = (pcnt == `VB_PCNT_END);

    always_ff @(posedge clk) begin
        if (reset || timing.restart) begin
            pcnt        <= 8'd0;
            skip_cnt    <= 3'd0;
            skip_done   <= 1'b0;
            fetch_cycle <= 3'd0;
            shift_cnt   <= 4'd0;
        end else if (ce) begin
            // Fetch counter saturates at 7 until the shifter reloads
            if (!(&fetch_cycle)) begin
                fetch_cycle <= fetch_cycle + 3'd1;
            end
            if (!shift_empty) begin
                shift_cnt <= shift_cnt - 4'd1;
            end
            if (fetch_done && shift_cnt <= 4'd1) begin
                shift_cnt   <= 4'd8;
                fetch_cycle <= 3'd0;
            end

            // Pixels move only while the shifter holds data
            if (!shift_empty) begin
                if (!skip_done) begin
                    if (!skip_end) skip_cnt <= skip_cnt + 3'd1;
                    else           skip_done <= 1'b1;
                end
                if (!skip_en && !pcnt_at_end) begin
                    pcnt <= pcnt + 8'd1;
                end
            end

            if (timing.pcnt_reset) begin
                pcnt      <= 8'd0;
                skip_cnt  <= 3'd0;
                skip_done <= 1'b0;
            end
        end
    end

    // Counts 8 to 167 reach the display
    assign pixel_strobe = timing.draw && !timing.vblank && !skip_en && !shift_empty &&
                          (pcnt >= `VB_PCNT_VISIBLE) && !pcnt_at_end;

endmodule

// ==== design/lcd_output.sv ====
// ----------------------------------------------------------------------
// LCD output stage, pixel enable and output colour select
// ----------------------------------------------------------------------
`include "video_bypass_defines.svh"

module lcd_output (
    input  logic        clk,
    input  logic        reset,
    input  logic        ce,
    input  logic        pixel_strobe,
    input  logic        is_gbc_mode,
    input  logic        palette_off,
    input  logic        custom_palette_ena,
    input  logic [63:0] palette_bg_in,
    input  logic [14:0] bg_color0,
    output logic        lcd_clkena,
    output logic [14:0] lcd_data
);

    // Pixel enable trails the strobe by one enable
    always_ff @(posedge clk) begin
        if (reset) begin
            lcd_clkena <= 1'b0;
        end else if (ce) begin
            lcd_clkena <= pixel_strobe;
        end
    end

    // Custom palette colour 0 sits in the two low bytes
    always_comb begin
        if (is_gbc_mode || !palette_off) begin
            lcd_data = `VB_WHITE;
        end else if (custom_palette_ena) begin
            lcd_data = palette_bg_in[14:0];
        end else begin
            lcd_data = bg_color0;
        end
    end

endmodule

// ==== design/video_bypass.sv ====
// ----------------------------------------------------------------------
// Bypass picture unit top level
// Keeps display timing in step with a real picture unit elsewhere
// ----------------------------------------------------------------------
module video_bypass (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ce,
    input  logic                     ce_cpu,
    input  logic                     is_gbc,
    input  logic                     is_gbc_mode,
    input  logic                     palette_off,
    input  logic                     custom_palette_ena,
    input  logic [63:0]              palette_bg_in,
    input  logic                     cpu_sel_reg,
    input  logic [7:0]               cpu_addr,
    input  logic                     cpu_wr,
    input  logic [7:0]               cpu_di,
    input  logic [1:0]               mode_real,
    output logic                     lcd_on,
    output logic                     lcd_clkena,
    output logic [14:0]              lcd_data,
    output logic                     lcd_vsync,
    output logic                     overwrite,
    output logic                     vsync_overwrite,
    output video_bypass_pkg::mode_t  mode
);
    import video_bypass_pkg::*;

    cpu_wr_t      cpu;
    lcd_regs_t    regs;
    line_timing_t timing;
    logic [14:0]  bg_color0;
    logic         restart;
    logic         pcnt_at_end;
    logic         pixel_strobe;

    assign cpu = '{sel: cpu_sel_reg, wr: cpu_wr, addr: cpu_addr, data: cpu_di};

    lcd_reg_file i_lcd_reg_file (
        .clk, .reset, .ce_cpu, .is_gbc, .is_gbc_mode,
        .cpu, .mode, .regs, .bg_color0
    );

    lcd_restart_seq i_lcd_restart_seq (
        .clk, .reset, .ce, .regs, .lcd_vsync, .mode_real,
        .restart, .overwrite, .vsync_overwrite, .lcd_on
    );

    video_timing_ctrl i_video_timing_ctrl (
        .clk, .reset, .ce, .is_gbc, .lcd_on, .restart, .pcnt_at_end,
        .timing, .lcd_vsync, .mode
    );

    pixel_pacer i_pixel_pacer (
        .clk, .reset, .ce, .timing, .regs, .pcnt_at_end, .pixel_strobe
    );

    lcd_output i_lcd_output (
        .clk, .reset, .ce, .pixel_strobe, .is_gbc_mode, .palette_off,
        .custom_palette_ena, .palette_bg_in, .bg_color0, .lcd_clkena, .lcd_data
    );

endmodule

// ==== sim/video_bypass_assertions.sv ====
// ----------------------------------------------------------------------
// Bound checks on the mode readback and the pixel enable
// ----------------------------------------------------------------------
module video_bypass_assertions (
    input logic                     clk,
    input logic                     reset,
    input video_bypass_pkg::mode_t  mode,
    input logic                     lcd_clkena
);
    import video_bypass_pkg::*;

    // The bypass unit has no OAM search, so mode 2 never shows
    mode_never_oam: assert property (@(posedge clk) disable iff (reset)
        mode != MODE_OAM)
        else $error("mode reads OAM search");

    // No pixel reaches the display during vertical blank
    no_pixel_in_vblank: assert property (@(posedge clk) disable iff (reset)
        !(lcd_clkena && mode == MODE_VBLANK))
        else $error("pixel enable high while mode is vblank");

endmodule

// ==== sim/video_bypass_tb.sv ====
// ----------------------------------------------------------------------
// Testbench for the bypass picture unit
// LFSR stimulus checked against a frame, palette and sequencer model
// ----------------------------------------------------------------------
`include "video_bypass_defines.svh"

module video_bypass_tb;
    import video_bypass_pkg::*;

    localparam int FRAME_CE       = 154 * 114 * 4;
    localparam int FRAME_PIXELS   = 144 * 160;
    localparam int MAX_CE_SPACING = 4;
    localparam int WATCHDOG_TIME  = 3 * FRAME_CE * MAX_CE_SPACING * 20 * 2;

    // Re-enable sequencer states in model order
    localparam logic [2:0] ST_IDLE        = 3'd0;
    localparam logic [2:0] ST_WAIT_VSYNC  = 3'd1;
    localparam logic [2:0] ST_WAIT_VBLANK = 3'd2;
    localparam logic [2:0] ST_WAIT_OAM    = 3'd3;
    localparam logic [2:0] ST_WAIT_CE     = 3'd4;

    logic clk = 1'b0;
    logic reset, ce, ce_cpu, is_gbc, is_gbc_mode, palette_off, custom_palette_ena;
    logic [63:0] palette_bg_in;
    logic cpu_sel_reg, cpu_wr;
    logic [7:0] cpu_addr, cpu_di;
    logic [1:0] mode_real;
    logic lcd_on, lcd_clkena, lcd_vsync, overwrite, vsync_overwrite;
    logic [14:0] lcd_data;
    mode_t mode;

    // Reference model state
    logic [15:0] lfsr_state = 16'd22872;
    logic [7:0]  pal_model [64];
    bit          pal_valid [64];
    logic [2:0]  seq_st;
    logic        en_m, en_d_m, vsync_q;
    int ce_cnt = 0, pix_cnt = 0, frame_ce = 0, frame_pix = 0, rise_cnt = 0;

    video_bypass i_video_bypass (
        .clk(clk), .reset(reset), .ce(ce), .ce_cpu(ce_cpu), .is_gbc(is_gbc),
        .is_gbc_mode(is_gbc_mode), .palette_off(palette_off),
        .custom_palette_ena(custom_palette_ena), .palette_bg_in(palette_bg_in),
        .cpu_sel_reg(cpu_sel_reg), .cpu_addr(cpu_addr), .cpu_wr(cpu_wr), .cpu_di(cpu_di),
        .mode_real(mode_real), .lcd_on(lcd_on), .lcd_clkena(lcd_clkena),
        .lcd_data(lcd_data), .lcd_vsync(lcd_vsync), .overwrite(overwrite),
        .vsync_overwrite(vsync_overwrite), .mode(mode)
    );

    bind video_bypass video_bypass_assertions i_video_bypass_assertions (
        .clk(clk), .reset(reset), .mode(mode), .lcd_clkena(lcd_clkena)
    );

    always #10 clk = ~clk;

    initial begin
        #(WATCHDOG_TIME);
        $display("ERROR: watchdog expired before all tests finished");
        $display("TEST FAILED");
        $fatal(1, "Simulation timed out");
    end

    // 16 bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[62:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Check %s failed", name);
        end
    endtask

    task automatic fail_run(input string why);
        $display("ERROR: %s", why);
        $display("TEST FAILED");
        $fatal(1, "Run aborted");
    endtask

    // Enables with random gaps of up to three idle clocks
    task automatic run_ce(input int count);
        logic [63:0] gap;
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            ce <= 1'b1;
            take_bits(2, gap);
            repeat (gap[1:0]) begin
                @(posedge clk);
                ce <= 1'b0;
            end
        end
        @(posedge clk);
        ce <= 1'b0;
    endtask

    // One register write with ce held low, returns the mode it met
    task automatic cpu_write(input logic [7:0] addr, input logic [7:0] data,
                             output mode_t seen);
        @(posedge clk);
        ce          <= 1'b0;
        ce_cpu      <= 1'b1;
        cpu_sel_reg <= 1'b1;
        cpu_wr      <= 1'b1;
        cpu_addr    <= addr;
        cpu_di      <= data;
        @(negedge clk);
        seen = mode;
        @(posedge clk);
        ce_cpu      <= 1'b0;
        cpu_sel_reg <= 1'b0;
        cpu_wr      <= 1'b0;
    endtask

    //----------------------------------------------------------------------
    // Frame monitor, enables and pixel enables between vsync rises
    always @(negedge clk) begin
        if (!reset) begin
            if (lcd_vsync && !vsync_q) begin
                frame_ce  = ce_cnt;
                frame_pix = pix_cnt;
                rise_cnt  = rise_cnt + 1;
                ce_cnt    = 0;
                pix_cnt   = 0;
            end
            // Each enable closes one held value of the pixel enable
            if (ce) begin
                ce_cnt = ce_cnt + 1;
                if (lcd_clkena) pix_cnt = pix_cnt + 1;
            end
            vsync_q = lcd_vsync;
        end
    end

    //----------------------------------------------------------------------
    // Re-enable sequencer model, outputs compared every clock
    always @(negedge clk) begin
        if (reset) begin
            seq_st = ST_IDLE;
            en_m   = 1'b0;
            en_d_m = 1'b0;
        end else begin
            check_value("seq_overwrite", seq_st >= ST_WAIT_VSYNC && seq_st <= ST_WAIT_OAM,
                        overwrite);
            check_value("seq_vsync_overwrite",
                        seq_st == ST_WAIT_VBLANK || seq_st == ST_WAIT_OAM, vsync_overwrite);
            check_value("seq_lcd_on", !(seq_st == ST_WAIT_VBLANK || seq_st == ST_WAIT_OAM),
                        lcd_on);
            // Next state as the DUT sees the inputs on the coming edge
            case (seq_st)
                ST_IDLE:        if (en_m && !en_d_m) seq_st = ST_WAIT_VSYNC;
                ST_WAIT_VSYNC:  if (lcd_vsync) seq_st = ST_WAIT_VBLANK;
                ST_WAIT_VBLANK: if (mode_real == 2'd1) seq_st = ST_WAIT_OAM;
                ST_WAIT_OAM:    if (ce && mode_real == 2'd2) seq_st = ST_WAIT_CE;
                ST_WAIT_CE:     if (ce) seq_st = 3'd5;
                default:        if (mode_real == 2'd0) seq_st = ST_IDLE;
            endcase
            if (ce) en_d_m = en_m;
            if (ce_cpu && cpu_sel_reg && cpu_wr && cpu_addr == `VB_ADDR_LCDC) en_m = cpu_di[7];
        end
    end

    //----------------------------------------------------------------------
    // Test sequence
    initial begin
        logic [63:0] rnd;
        logic [5:0]  pal_idx;
        logic [14:0] expect_data;
        mode_t       seen;
        int          writes;
        int          blocked;
        reset = 1'b1;
        ce = 1'b0;
        ce_cpu = 1'b0;
        is_gbc = 1'b1;
        is_gbc_mode = 1'b1;
        palette_off = 1'b0;
        custom_palette_ena = 1'b0;
        palette_bg_in = '0;
        cpu_sel_reg = 1'b0;
        cpu_wr = 1'b0;
        cpu_addr = '0;
        cpu_di = '0;
        mode_real = 2'd0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // Levels after reset, no enable given yet
        check_value("reset_clkena", 0, lcd_clkena);
        check_value("reset_vsync", 0, lcd_vsync);
        check_value("reset_overwrite", 0, overwrite);
        check_value("reset_vsync_overwrite", 0, vsync_overwrite);
        check_value("reset_lcd_on", 1, lcd_on);
        check_value("reset_mode", 0, mode);

        // Frame length and pixel count with a random fine scroll
        take_bits(3, rnd);
        cpu_write(`VB_ADDR_SCX, {5'd0, rnd[2:0]}, seen);
        while (rise_cnt < 2) begin
            run_ce(64);
        end
        check_value("frame_length", FRAME_CE, frame_ce);
        check_value("frame_pixels", FRAME_PIXELS, frame_pix);

        // Palette writes, blocked while drawing, index always steps
        cpu_write(`VB_ADDR_BGPI, 8'h80, seen);
        pal_idx = 6'd0;
        writes  = 0;
        blocked = 0;
        while ((writes < 64 || !(pal_valid[0] && pal_valid[1])) && writes < 1024) begin
            take_bits(8, rnd);
            run_ce(rnd[7:0]);
            take_bits(8, rnd);
            cpu_write(`VB_ADDR_BGPD, rnd[7:0], seen);
            if (seen != MODE_DRAW) begin
                pal_model[pal_idx] = rnd[7:0];
                pal_valid[pal_idx] = 1'b1;
            end else begin
                blocked = blocked + 1;
            end
            pal_idx = pal_idx + 6'd1;
            writes  = writes + 1;
        end
        if (!(pal_valid[0] && pal_valid[1])) fail_run("palette entries 0 and 1 never written");
        if (blocked == 0) fail_run("no palette write fell in draw mode");
        @(posedge clk);
        is_gbc_mode <= 1'b0;
        palette_off <= 1'b1;
        @(negedge clk);
        check_value("palette_color0", {pal_model[1][6:0], pal_model[0]}, lcd_data);

        // Output colour select with random control inputs
        for (int i = 0; i < 16; i++) begin
            take_bits(64, rnd);
            @(posedge clk);
            palette_bg_in <= rnd;
            take_bits(3, rnd);
            is_gbc_mode        <= rnd[0];
            palette_off        <= rnd[1];
            custom_palette_ena <= rnd[2];
            @(negedge clk);
            if (is_gbc_mode || !palette_off) expect_data = `VB_WHITE;
            else if (custom_palette_ena) expect_data = palette_bg_in[14:0];
            else expect_data = {pal_model[1][6:0], pal_model[0]};
            check_value("colour_select", expect_data, lcd_data);
        end

        // Display re-enable, the real unit is drawing at first
        @(posedge clk);
        mode_real <= 2'd3;
        cpu_write(`VB_ADDR_LCDC, 8'h00, seen);
        run_ce(8);
        cpu_write(`VB_ADDR_LCDC, 8'h80, seen);
        while (seq_st != ST_WAIT_VBLANK) begin
            run_ce(16);
        end
        run_ce(20);
        @(posedge clk);
        mode_real <= 2'd1;
        run_ce(4);
        @(posedge clk);
        mode_real <= 2'd2;
        run_ce(4);
        @(posedge clk);
        mode_real <= 2'd3;
        run_ce(4);
        @(posedge clk);
        mode_real <= 2'd0;
        run_ce(4);
        if (seq_st != ST_IDLE) fail_run("re-enable sequence did not return to idle");

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== video_bypass.f ====
+incdir+design
design/video_bypass_pkg.sv
design/lcd_restart_seq.sv
design/video_timing_ctrl.sv
design/lcd_reg_file.sv
design/pixel_pacer.sv
design/lcd_output.sv
design/video_bypass.sv
sim/video_bypass_assertions.sv
sim/video_bypass_tb.sv
